/* build.f */
hw/eth_fcs_pkg.sv
hw/eth_crc_8.sv
hw/axis_eth_fcs.sv
hw/axis_eth_fcs_insert.sv
hw/axis_eth_fcs_check.sv
hw/eth_fcs_top.sv
tb/tb_eth_fcs.sv

/* hw/axis_eth_fcs.sv */
`timescale 1ns/10ps
`default_nettype none

// FCS generator for a byte-wide AXI-Stream frame, the result shows up after tlast
module axis_eth_fcs import eth_fcs_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  input_axis_tdata,  // Frame byte
    input  logic        input_axis_tvalid, // Byte is present this cycle
    output logic        input_axis_tready, // Always ready, the stream cannot be stalled
    input  logic        input_axis_tlast,  // Final byte of the frame
    input  logic        input_axis_tuser,  // Error mark from upstream, evaluated by the checker
    output logic [31:0] output_fcs,        // Inverted CRC of the whole frame
    output logic        output_fcs_valid   // One cycle pulse, one cycle after tlast
);

    logic [31:0] crc_state;     // Running CRC of the frame so far
    logic [31:0] crc_next;      // CRC including the current byte
    logic [31:0] fcs_reg;       // Captured frame result
    logic        fcs_valid_reg; // Result strobe

    assign input_axis_tready = 1'b1;          // Receive side has no flow control
    assign output_fcs        = fcs_reg;
    assign output_fcs_valid  = fcs_valid_reg;

    eth_crc_8 u_crc (
        .data_in   (input_axis_tdata),
        .crc_state (crc_state),
        .crc_next  (crc_next)
    );

    always_ff @(posedge clk) begin
        fcs_valid_reg <= 1'b0;                        // Strobe lasts a single cycle
        if (input_axis_tvalid) begin
            if (input_axis_tlast) begin
                crc_state     <= CRC_INIT;            // Next frame starts from the preset
                fcs_reg       <= ~crc_next;           // Ethernet sends the complemented CRC
                fcs_valid_reg <= 1'b1;
            end else begin
                crc_state <= crc_next;                // Accumulate the payload byte
            end
        end
        if (rst) begin
            crc_state     <= CRC_INIT;
            fcs_valid_reg <= 1'b0;
        end
    end

    // The result strobe is a single cycle pulse, which also rules out a tlast byte
    // right after another tlast byte
    assert property (@(posedge clk) disable iff (rst)
        output_fcs_valid |=> !output_fcs_valid);

    // Control flags on a valid byte must be driven to known levels by the sender
    assert property (@(posedge clk) disable iff (rst)
        input_axis_tvalid |-> !$isunknown({input_axis_tlast, input_axis_tuser}));

endmodule

`default_nettype wire

/* hw/axis_eth_fcs_check.sv */
`timescale 1ns/10ps
`default_nettype none

// Receive path, runs each frame with its FCS through the generator and judges it
module axis_eth_fcs_check import eth_fcs_pkg::*; #(
    parameter int COUNT_WIDTH = 16 // Width of the good and bad frame counters
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0]             in_tdata,   // Frame byte, FCS included
    input  logic                   in_tvalid,
    output logic                   in_tready,  // Tied high inside the generator
    input  logic                   in_tlast,
    input  logic                   in_tuser,   // Error mark, a frame with it set on the last byte is bad
    output logic                   frame_good, // Pulse two cycles after tlast
    output logic                   frame_bad,  // Pulse two cycles after tlast
    output logic [COUNT_WIDTH-1:0] good_count, // Saturating count of good frames
    output logic [COUNT_WIDTH-1:0] bad_count   // Saturating count of bad frames
);

    logic [31:0] fcs;        // Generator result
    logic        fcs_valid;  // Generator result strobe
    logic        last_user;  // tuser of the last byte, kept until the result arrives
    logic        fcs_ok;     // Result matches the good frame residue

    axis_eth_fcs u_fcs (
        .clk               (clk),
        .rst               (rst),
        .input_axis_tdata  (in_tdata),
        .input_axis_tvalid (in_tvalid),
        .input_axis_tready (in_tready),
        .input_axis_tlast  (in_tlast),
        .input_axis_tuser  (in_tuser),
        .output_fcs        (fcs),
        .output_fcs_valid  (fcs_valid)
    );

    assign fcs_ok = (fcs == FCS_GOOD) && !last_user;

    always_ff @(posedge clk) begin
        if (in_tvalid && in_tlast) begin
            last_user <= in_tuser;                   // Lines up with the result next cycle
        end
    end

    always_ff @(posedge clk) begin
        frame_good <= 1'b0;
        frame_bad  <= 1'b0;
        if (fcs_valid) begin
            frame_good <= fcs_ok;
            frame_bad  <= !fcs_ok;
            if (fcs_ok && good_count != {COUNT_WIDTH{1'b1}}) begin
                good_count <= good_count + 1'b1;     // Stops at the top value
            end
            if (!fcs_ok && bad_count != {COUNT_WIDTH{1'b1}}) begin
                bad_count <= bad_count + 1'b1;
            end
        end
        if (rst) begin
            frame_good <= 1'b0;
            frame_bad  <= 1'b0;
            good_count <= '0;
            bad_count  <= '0;
        end
    end

    // Exactly one verdict per generator result, never both at once
    assert property (@(posedge clk) disable iff (rst)
        (frame_good || frame_bad) |-> (frame_good != frame_bad) && $past(fcs_valid));

endmodule

`default_nettype wire

/* hw/axis_eth_fcs_insert.sv */
`timescale 1ns/10ps
`default_nettype none

// Transmit path, forwards the payload and appends the four FCS bytes LSB first
module axis_eth_fcs_insert import eth_fcs_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] in_tdata,   // Payload byte from the source
    input  logic       in_tvalid,
    output logic       in_tready,  // Follows out_tready while payload flows
    input  logic       in_tlast,   // Last payload byte, the FCS goes after it
    input  logic       in_tuser,   // Error mark on a payload byte
    output logic [7:0] out_tdata,
    output logic       out_tvalid,
    input  logic       out_tready,
    output logic       out_tlast,  // Set on the fourth FCS byte only
    output logic       out_tuser   // Frame error flag, shown on every FCS byte
);

    fcs_ins_state_e state;    // Payload or FCS phase
    logic [31:0]    crc_reg;  // CRC of the payload accepted so far
    logic [31:0]    crc_next; // CRC including the byte at the input
    logic [31:0]    fcs_reg;  // Final FCS, held while its bytes go out
    logic [1:0]     byte_idx; // Which FCS byte is on the output
    logic           err_reg;  // OR of tuser over the current frame
    logic           in_xfer;  // Payload byte accepted this cycle
    logic           fcs_xfer; // FCS byte accepted this cycle

    eth_crc_8 u_crc (
        .data_in   (in_tdata),
        .crc_state (crc_reg),
        .crc_next  (crc_next)
    );

    assign in_xfer  = in_tvalid && in_tready;
    assign fcs_xfer = (state == ST_FCS) && out_tready; // Output is always valid in ST_FCS

    // The output mux adds no register, so payload leaves in the same cycle it arrives
    always_comb begin
        unique case (state)
            ST_DATA: begin
                out_tdata  = in_tdata;              // Straight pass of the payload
                out_tvalid = in_tvalid;
                out_tlast  = 1'b0;                  // Frame continues with the FCS
                out_tuser  = in_tuser;
                in_tready  = out_tready;            // Sink stalls reach the source directly
            end
            ST_FCS: begin
                out_tdata  = fcs_reg[{byte_idx, 3'b000} +: 8]; // LSB first
                out_tvalid = 1'b1;
                out_tlast  = (byte_idx == 2'd3);
                out_tuser  = err_reg;
                in_tready  = 1'b0;                  // Next frame waits for the FCS
            end
        endcase
    end

    always_ff @(posedge clk) begin
        case (state)
            ST_DATA: begin
                if (in_xfer) begin
                    crc_reg <= crc_next;            // Fold in the accepted byte
                    err_reg <= err_reg | in_tuser;  // Remember any marked byte
                    if (in_tlast) begin
                        state    <= ST_FCS;
                        fcs_reg  <= ~crc_next;      // Complemented CRC is the FCS
                        byte_idx <= 2'd0;
                        crc_reg  <= CRC_INIT;       // Ready for the next frame
                    end
                end
            end
            ST_FCS: begin
                if (fcs_xfer) begin
                    byte_idx <= byte_idx + 2'd1;
                    if (byte_idx == 2'd3) begin
                        state   <= ST_DATA;         // Frame done
                        err_reg <= 1'b0;            // Fresh flag for the next frame
                    end
                end
            end
            default: state <= ST_DATA;
        endcase
        if (rst) begin
            state    <= ST_DATA;
            crc_reg  <= CRC_INIT;
            err_reg  <= 1'b0;
            byte_idx <= 2'd0;
        end
    end

    // The cycle after the payload tlast is taken the source is held off
    assert property (@(posedge clk) disable iff (rst)
        (in_xfer && in_tlast) |=> (state == ST_FCS) && !in_tready);

    // A stalled byte stays put, in ST_DATA this relies on the source holding its byte too
    assert property (@(posedge clk) disable iff (rst)
        (out_tvalid && !out_tready) |=> out_tvalid && $stable(out_tdata));

endmodule

`default_nettype wire

/* hw/eth_crc_8.sv */
`timescale 1ns/10ps
`default_nettype none

// One byte step of the reflected CRC-32, shared by the transmit and receive paths
module eth_crc_8 import eth_fcs_pkg::*; (
    input  logic [7:0]  data_in,   // Byte to fold into the CRC, bit 0 goes first
    input  logic [31:0] crc_state, // Current CRC register value
    output logic [31:0] crc_next   // CRC register value after this byte
);

    logic [31:0] crc_work; // Intermediate value while the eight bits are applied

    // The bit loop unrolls into a flat XOR network, so the whole byte fits in one cycle.
    // Each step shifts right and folds in the polynomial when the outgoing bit differs
    // from the data bit, which is the LSB-first serial CRC used on the Ethernet wire.
    always_comb begin
        crc_work = crc_state;                              // Start from the stored register
        for (int i = 0; i < 8; i++) begin
            if (crc_work[0] ^ data_in[i]) begin
                crc_work = (crc_work >> 1) ^ CRC_POLY;     // Feedback tap set for this bit
            end else begin
                crc_work = crc_work >> 1;                  // No feedback, plain shift
            end
        end
        crc_next = crc_work;                               // Result after all eight bits
    end

endmodule

`default_nettype wire

/* hw/eth_fcs_pkg.sv */
`default_nettype none

package eth_fcs_pkg;

    // Reflected form of the IEEE 802.3 CRC-32 generator polynomial
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF; // Register preset at the start of every frame

    // Running a frame through the CRC together with its own correct FCS always leaves
    // the same residue, so the inverted register value is a fixed constant
    localparam logic [31:0] FCS_GOOD = 32'h2144_DF1C;

    // States of the transmit FCS inserter
    typedef enum logic {
        ST_DATA = 1'b0, // Payload bytes flow from input to output
        ST_FCS  = 1'b1  // Input is held off while the four FCS bytes go out
    } fcs_ins_state_e;

endpackage

`default_nettype wire

/* hw/eth_fcs_top.sv */
`timescale 1ns/10ps
`default_nettype none

// Ethernet FCS subsystem with the transmit inserter and the receive checker side by side
module eth_fcs_top #(
    parameter int COUNT_WIDTH = 16 // Frame counter width, handed to the checker
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0]             tx_in_tdata,    // Transmit payload from the MAC side
    input  logic                   tx_in_tvalid,
    output logic                   tx_in_tready,
    input  logic                   tx_in_tlast,
    input  logic                   tx_in_tuser,
    output logic [7:0]             tx_out_tdata,   // Payload followed by the FCS
    output logic                   tx_out_tvalid,
    input  logic                   tx_out_tready,
    output logic                   tx_out_tlast,
    output logic                   tx_out_tuser,
    input  logic [7:0]             rx_tdata,       // Received frame with its FCS
    input  logic                   rx_tvalid,
    output logic                   rx_tready,
    input  logic                   rx_tlast,
    input  logic                   rx_tuser,
    output logic                   rx_frame_good,
    output logic                   rx_frame_bad,
    output logic [COUNT_WIDTH-1:0] rx_good_count,
    output logic [COUNT_WIDTH-1:0] rx_bad_count
);

    axis_eth_fcs_insert u_insert (
        .clk        (clk),
        .rst        (rst),
        .in_tdata   (tx_in_tdata),
        .in_tvalid  (tx_in_tvalid),
        .in_tready  (tx_in_tready),
        .in_tlast   (tx_in_tlast),
        .in_tuser   (tx_in_tuser),
        .out_tdata  (tx_out_tdata),
        .out_tvalid (tx_out_tvalid),
        .out_tready (tx_out_tready),
        .out_tlast  (tx_out_tlast),
        .out_tuser  (tx_out_tuser)
    );

    axis_eth_fcs_check #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_check (
        .clk        (clk),
        .rst        (rst),
        .in_tdata   (rx_tdata),
        .in_tvalid  (rx_tvalid),
        .in_tready  (rx_tready),
        .in_tlast   (rx_tlast),
        .in_tuser   (rx_tuser),
        .frame_good (rx_frame_good),
        .frame_bad  (rx_frame_bad),
        .good_count (rx_good_count),
        .bad_count  (rx_bad_count)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile with Verilator, run the loopback testbench and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_eth_fcs \
    -f build.f -o tb_eth_fcs &&
./obj_dir/tb_eth_fcs | tee sim.log &&
grep -q "Finished with no errors" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* tb/tb_eth_fcs.sv */
`timescale 1ns/10ps
`default_nettype none

// Loopback testbench, the transmit output of the DUT feeds its own receive input
module tb_eth_fcs import eth_fcs_pkg::*; ();

    localparam int N_CLEAN  = 8;           // Frames in the clean frame test
    localparam int N_FRAMES = N_CLEAN + 2; // Plus one bit flip frame and one tuser frame

    logic        clk;
    logic        rst;
    logic [7:0]  tx_in_tdata;
    logic        tx_in_tvalid;
    logic        tx_in_tready;
    logic        tx_in_tlast;
    logic        tx_in_tuser;
    logic [7:0]  tx_out_tdata;
    logic        tx_out_tvalid;
    logic        tx_out_tready;
    logic        tx_out_tlast;
    logic        tx_out_tuser;
    logic [7:0]  rx_tdata;
    logic        rx_tvalid;
    logic        rx_tready;
    logic        rx_tlast;
    logic        rx_tuser;
    logic        rx_frame_good;
    logic        rx_frame_bad;
    logic [15:0] rx_good_count;
    logic [15:0] rx_bad_count;

    logic [7:0]  exp_q[$];       // Bytes still expected on tx_out, payload then FCS
    logic [31:0] rng;            // Xorshift state
    logic        in_taken;       // Payload byte transferred on the last edge
    logic        in_fcs;         // Between the payload tlast and the fourth FCS byte
    logic        stall_en;       // Random stalls on tx_out_tready
    logic        flip_en;        // Corrupt one byte on the loopback path
    logic        user_exp;       // tuser expected on the FCS bytes of the current frame
    int          flip_idx;       // Byte of the frame that gets corrupted
    int          flip_bit;       // Bit that gets flipped in that byte
    int          out_idx;        // Position of the next tx_out byte in its frame
    int          lens[N_FRAMES]; // Payload length of every frame
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit;
    int          good_sent;      // Frames that should have been judged good
    int          bad_sent;

    // Only transferred bytes reach the checker, the flip mask hits a single frame byte
    assign rx_tdata  = tx_out_tdata ^ ((flip_en && out_idx == flip_idx) ? 8'(1 << flip_bit) : 8'h00);
    assign rx_tvalid = tx_out_tvalid && tx_out_tready;
    assign rx_tlast  = tx_out_tlast;
    assign rx_tuser  = tx_out_tuser;

    eth_fcs_top #(
        .COUNT_WIDTH (16)
    ) u_eth_fcs_top (
        .clk           (clk),
        .rst           (rst),
        .tx_in_tdata   (tx_in_tdata),
        .tx_in_tvalid  (tx_in_tvalid),
        .tx_in_tready  (tx_in_tready),
        .tx_in_tlast   (tx_in_tlast),
        .tx_in_tuser   (tx_in_tuser),
        .tx_out_tdata  (tx_out_tdata),
        .tx_out_tvalid (tx_out_tvalid),
        .tx_out_tready (tx_out_tready),
        .tx_out_tlast  (tx_out_tlast),
        .tx_out_tuser  (tx_out_tuser),
        .rx_tdata      (rx_tdata),
        .rx_tvalid     (rx_tvalid),
        .rx_tready     (rx_tready),
        .rx_tlast      (rx_tlast),
        .rx_tuser      (rx_tuser),
        .rx_frame_good (rx_frame_good),
        .rx_frame_bad  (rx_frame_bad),
        .rx_good_count (rx_good_count),
        .rx_bad_count  (rx_bad_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Bytewise reflected CRC-32 as in IEEE 802.3, returns the complemented register
    function automatic logic [31:0] crc32_ref(input logic [7:0] bytes[$]);
        logic [31:0] crc;
        crc = 32'hFFFF_FFFF;
        foreach (bytes[i]) begin
            crc = crc ^ {24'h0, bytes[i]};                 // Byte enters at the low end
            repeat (8) crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
        end
        return ~crc;
    endfunction

    // Advance one clock, note whether the payload byte went in, then redraw the stall
    task automatic step();
        @(posedge clk);
        in_taken = tx_in_tvalid && tx_in_tready;
        #2;
        rng = xorshift(rng);
        tx_out_tready = !stall_en || (rng[1:0] != 2'b00); // Stalls about one cycle in four
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) $display("Test %s passed", name);
        else $display("Test %s failed with %0d errors", name, errors - errs_before);
    endtask

    // Send one payload, wait for the receive verdict and check pulses and counters
    task automatic send_frame(input int len, input int user_idx);
        logic [7:0]  pay[$];
        logic [7:0]  all[$];
        logic [31:0] fcs;
        logic        bad_exp;
        for (int i = 0; i < len; i++) begin
            rng = xorshift(rng);
            pay.push_back(rng[7:0]);
        end
        fcs = crc32_ref(pay);
        all = pay;
        for (int k = 0; k < 4; k++) all.push_back(fcs[8*k +: 8]); // LSB goes first
        assert (crc32_ref(all) == FCS_GOOD) else begin
            $display("Reference CRC of a frame with its FCS does not give the good residue");
            errors++;
        end
        user_exp = (user_idx >= 0);
        exp_q    = all;
        bad_exp  = flip_en || (user_idx >= 0);
        for (int i = 0; i < len; i++) begin
            tx_in_tdata  = pay[i];
            tx_in_tvalid = 1'b1;
            tx_in_tlast  = (i == len - 1);
            tx_in_tuser  = (i == user_idx);
            do step(); while (!in_taken);                   // Held until accepted
        end
        tx_in_tvalid = 1'b0;
        tx_in_tlast  = 1'b0;
        tx_in_tuser  = 1'b0;
        do step(); while (!(rx_frame_good || rx_frame_bad)); // Watchdog bounds this wait
        if (bad_exp) bad_sent++;
        else good_sent++;
        assert (rx_frame_good == !bad_exp) else begin
            $display("Fail rx_frame_good expected %h actual %h", !bad_exp, rx_frame_good);
            errors++;
        end
        assert (rx_frame_bad == bad_exp) else begin
            $display("Fail rx_frame_bad expected %h actual %h", bad_exp, rx_frame_bad);
            errors++;
        end
        assert (rx_good_count == 16'(good_sent)) else begin
            $display("Fail rx_good_count expected %h actual %h", 16'(good_sent), rx_good_count);
            errors++;
        end
        assert (rx_bad_count == 16'(bad_sent)) else begin
            $display("Fail rx_bad_count expected %h actual %h", 16'(bad_sent), rx_bad_count);
            errors++;
        end
    endtask

    // Output side monitor, compares each transferred byte with the expected queue
    always @(posedge clk) begin : monitor
        logic [7:0] exp_byte;
        if (rst) begin
            in_fcs  <= 1'b0;
            out_idx <= 0;
        end else begin
            assert (rx_tready) else begin
                $display("rx_tready went low although the receive input has no flow control");
                errors++;
            end
            if (in_fcs) begin
                assert (!tx_in_tready) else begin
                    $display("tx_in_tready was high while FCS bytes were still pending");
                    errors++;
                end
            end
            if (tx_out_tvalid && tx_out_tready) begin
                assert (exp_q.size() != 0) else begin
                    $display("A byte left tx_out when no byte was expected");
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_byte = exp_q.pop_front();
                    assert (tx_out_tdata == exp_byte) else begin
                        $display("Fail tx_out_tdata expected %h actual %h", exp_byte, tx_out_tdata);
                        errors++;
                    end
                    assert (tx_out_tlast == (exp_q.size() == 0)) else begin
                        $display("Fail tx_out_tlast expected %h actual %h", exp_q.size() == 0,
                                 tx_out_tlast);
                        errors++;
                    end
                    if (exp_q.size() < 4) begin
                        // The last four bytes of a frame are its FCS
                        assert (tx_out_tuser == user_exp) else begin
                            $display("Fail tx_out_tuser expected %h actual %h", user_exp,
                                     tx_out_tuser);
                            errors++;
                        end
                    end
                end
                out_idx <= tx_out_tlast ? 0 : out_idx + 1;
                if (tx_out_tlast) in_fcs <= 1'b0;
            end
            if (tx_in_tvalid && tx_in_tready && tx_in_tlast) in_fcs <= 1'b1;
        end
    end

    // A stalled output byte keeps its data and flags until it is taken
    assert property (@(posedge clk) disable iff (rst)
        (tx_out_tvalid && !tx_out_tready) |=>
            tx_out_tvalid && $stable({tx_out_tdata, tx_out_tlast, tx_out_tuser}))
        else begin
            $display("An output byte changed while tx_out_tready was holding it");
            errors++;
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout, the run did not end within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        int errs;
        rst           = 1'b1;
        tx_in_tdata   = 8'h00;
        tx_in_tvalid  = 1'b0;
        tx_in_tlast   = 1'b0;
        tx_in_tuser   = 1'b0;
        tx_out_tready = 1'b1;
        stall_en      = 1'b0;
        flip_en       = 1'b0;
        user_exp      = 1'b0;
        flip_idx      = 0;
        flip_bit      = 0;
        good_sent     = 0;
        bad_sent      = 0;
        rng           = 32'hb2ec_7f72;
        cycle_limit   = 200;
        for (int f = 0; f < N_FRAMES; f++) begin
            rng = xorshift(rng);
            lens[f] = int'(rng[4:0]) + 1;        // 1 to 32 payload bytes
            cycle_limit += 64 * (lens[f] + 4);  // FCS bytes count as sent bytes too
        end
        repeat (3) step();
        rst = 1'b0;
        errs = errors;
        step();
        assert (!tx_out_tvalid && !rx_frame_good && !rx_frame_bad) else begin
            $display("Valid or verdict outputs were high right after reset");
            errors++;
        end
        assert (rx_good_count == 16'h0) else begin
            $display("Fail rx_good_count expected 0000 actual %h", rx_good_count);
            errors++;
        end
        assert (rx_bad_count == 16'h0) else begin
            $display("Fail rx_bad_count expected 0000 actual %h", rx_bad_count);
            errors++;
        end
        report_test("reset_state", errs);
        errs = errors;
        stall_en = 1'b1;
        for (int f = 0; f < N_CLEAN; f++) send_frame(lens[f], -1);
        report_test("clean_frames", errs);
        errs = errors;
        rng      = xorshift(rng);
        flip_idx = int'(rng[15:0]) % (lens[N_CLEAN] + 4); // FCS bytes can be hit as well
        flip_bit = int'(rng[18:16]);
        flip_en  = 1'b1;
        send_frame(lens[N_CLEAN], -1);
        flip_en  = 1'b0;
        report_test("bit_flip", errs);
        errs = errors;
        rng = xorshift(rng);
        send_frame(lens[N_CLEAN + 1], int'(rng[15:0]) % lens[N_CLEAN + 1]);
        report_test("tuser_error", errs);
        $display("Frames good %0d, bad %0d, errors %0d", good_sent, bad_sent, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
